// ==== verilog.f ====
source/biu_axi_pkg.sv
source/biu_req_pkg.sv
source/biu_req_arbiter.sv
source/biu_read_channel.sv
source/biu_write_channel.sv
source/biu_top.sv
testbench/biu_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= biu_tb
FILELIST ?= verilog.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/biu_tb.sv ====
// ============================================================
// BIU testbench with core drivers, AXI slave model and checks
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module biu_tb;

  localparam int CYCLE_LIMIT = 2000;
  localparam int N_RD        = 16;
  localparam int N_WR        = 12;

  logic forever_cpuclk;
  logic reset;
  logic ifu_rd_valid, lsu_rd_valid, stb_wr_valid, vb_wr_valid;
  biu_req_pkg::core_rd_req_t ifu_rd_req, lsu_rd_req;
  biu_req_pkg::core_wr_req_t stb_wr_req, vb_wr_req;
  logic ifu_rd_ready, lsu_rd_ready, stb_wr_ready, vb_wr_ready;
  logic ifu_rsp_valid, lsu_rsp_valid, lsu_no_op;
  biu_req_pkg::core_rd_rsp_t rd_rsp;
  logic pad_arvalid, pad_arready, pad_awvalid, pad_awready, pad_wvalid, pad_wready;
  logic pad_rvalid, pad_bvalid;
  biu_axi_pkg::axi_ar_t pad_ar;
  biu_axi_pkg::axi_aw_t pad_aw;
  biu_axi_pkg::axi_w_t  pad_w;
  biu_axi_pkg::axi_r_t  pad_r;
  biu_axi_pkg::axi_b_t  pad_b;

  // Scoreboard and slave state
  int ifu_idx, lsu_idx, stb_idx, vb_idx;
  int wr_acc, aw_hs, w_hs, b_cnt, cycles;
  int data_errors, assert_errors;
  logic in_reset, rd_seen, rd_last_lsu;
  logic [15:0] lfsr;
  logic [7:0] rnd;
  logic [39:0] ar_addr_q[$], ifu_addr_q[$], lsu_addr_q[$], aw_addr_q[$], r_addr_q[$];
  logic [7:0] ar_id_q[$], aw_id_q[$], b_id_q[$], r_id_q[$];
  logic [3:0] ifu_id_q[$], lsu_id_q[$];
  logic [127:0] w_data_q[$];
  logic [15:0] w_strb_q[$];
  int r_due_q[$];

  biu_top u_dut (.*);

  initial begin
    forever_cpuclk = 1'b0;
    forever #10 forever_cpuclk = ~forever_cpuclk;
  end

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [7:0] next_bits(input int n);
    logic       fb;
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[6:0], fb};
    end
    next_bits = v;
  endfunction

  function automatic logic [127:0] rep(input logic [39:0] a);
    rep = {24'h0, a, 24'h0, a};
  endfunction

  function automatic biu_req_pkg::core_rd_req_t make_rd(input logic [1:0] src, input int i);
    make_rd       = '0;
    make_rd.addr  = {8'h80, 6'd0, src, 16'd0, i[3:0], 4'h0};
    make_rd.id    = i[3:0];
    make_rd.size  = 3'd4;
    make_rd.burst = 2'b01;
    make_rd.cache = 4'h2;
  endfunction

  function automatic biu_req_pkg::core_wr_req_t make_wr(input logic [1:0] src, input int i);
    make_wr       = '0;
    make_wr.addr  = {8'h40, 6'd0, src, 16'd0, i[3:0], 4'h0};
    make_wr.id    = i[3:0];
    make_wr.size  = 3'd4;
    make_wr.burst = 2'b01;
    make_wr.data  = {4{6'd0, src, 8'h5a, 12'd0, i[3:0]}};
    make_wr.strb  = ~(16'h1 << i[3:0]);
    make_wr.last  = 1'b1;
  endfunction

  task automatic report_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    data_errors++;
    $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic unexpected(input string what);
    data_errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic protocol_error(input string what);
    assert_errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // ============================================================
  // Protocol assertions
  // ============================================================
  a_ar_hold: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_arvalid && !pad_arready |=> pad_arvalid && $stable(pad_ar))
    else protocol_error("AR dropped or changed while stalled");
  a_aw_hold: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_awvalid && !pad_awready |=> pad_awvalid && $stable(pad_aw))
    else protocol_error("AW dropped or changed while stalled");
  a_w_hold: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_wvalid && !pad_wready |=> pad_wvalid && $stable(pad_w))
    else protocol_error("W dropped or changed while stalled");
  a_len_zero: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (!pad_arvalid || pad_ar.len == 8'd0) && (!pad_awvalid || pad_aw.len == 8'd0))
    else protocol_error("nonzero burst length on the pad");
  a_vb_first: assert property (@(posedge forever_cpuclk) disable iff (reset)
    vb_wr_valid |-> !stb_wr_ready)
    else protocol_error("stb granted over a waiting vb");
  a_r_route: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_rvalid |-> ifu_rsp_valid == (pad_r.id[7:6] == 2'd0)
      && lsu_rsp_valid == (pad_r.id[7:6] == 2'd1) && rd_rsp.id == pad_r.id[3:0])
    else protocol_error($sformatf("R id %0h routed wrong", pad_r.id));

  // ============================================================
  // Sample at the falling edge where everything has settled
  // ============================================================
  always @(negedge forever_cpuclk) begin
    in_reset = reset;
    if (!reset) begin
      cycles++;
      assert (lsu_no_op == (wr_acc == b_cnt))
        else report_value("lsu_no_op", lsu_no_op, wr_acc == b_cnt);
      // Round-robin when both compete
      if (ifu_rd_valid && lsu_rd_valid && (ifu_rd_ready || lsu_rd_ready) && rd_seen) begin
        assert (ifu_rd_ready == rd_last_lsu)
          else report_value("ifu_rd_ready", ifu_rd_ready, rd_last_lsu);
      end
      if (ifu_rd_valid && ifu_rd_ready) begin
        ar_addr_q.push_back(ifu_rd_req.addr);
        ar_id_q.push_back({4'h0, ifu_rd_req.id});
        ifu_addr_q.push_back(ifu_rd_req.addr);
        ifu_id_q.push_back(ifu_rd_req.id);
        ifu_idx++;
        rd_last_lsu = 1'b0;
        rd_seen = 1'b1;
      end
      if (lsu_rd_valid && lsu_rd_ready) begin
        ar_addr_q.push_back(lsu_rd_req.addr);
        ar_id_q.push_back({4'h4, lsu_rd_req.id});
        lsu_addr_q.push_back(lsu_rd_req.addr);
        lsu_id_q.push_back(lsu_rd_req.id);
        lsu_idx++;
        rd_last_lsu = 1'b1;
        rd_seen = 1'b1;
      end
      if (vb_wr_valid && vb_wr_ready) begin
        aw_addr_q.push_back(vb_wr_req.addr);
        aw_id_q.push_back({4'hc, vb_wr_req.id});
        w_data_q.push_back(vb_wr_req.data);
        w_strb_q.push_back(vb_wr_req.strb);
        vb_idx++;
        wr_acc++;
      end
      if (stb_wr_valid && stb_wr_ready) begin
        aw_addr_q.push_back(stb_wr_req.addr);
        aw_id_q.push_back({4'h8, stb_wr_req.id});
        w_data_q.push_back(stb_wr_req.data);
        w_strb_q.push_back(stb_wr_req.strb);
        stb_idx++;
        wr_acc++;
      end
      if (pad_arvalid && pad_arready) begin
        if (ar_addr_q.size() == 0) begin
          unexpected("AR on the pad with no read accepted");
        end else begin
          assert (pad_ar.addr == ar_addr_q[0])
            else report_value("pad_ar.addr", pad_ar.addr, ar_addr_q[0]);
          assert (pad_ar.id == ar_id_q[0])
            else report_value("pad_ar.id", pad_ar.id, ar_id_q[0]);
          rnd = next_bits(2);
          r_id_q.push_back(pad_ar.id);
          r_addr_q.push_back(pad_ar.addr);
          r_due_q.push_back(cycles + int'(rnd % 3) + 1);
          void'(ar_addr_q.pop_front());
          void'(ar_id_q.pop_front());
        end
      end
      if (pad_awvalid && pad_awready) begin
        if (aw_addr_q.size() == 0) begin
          unexpected("AW on the pad with no write accepted");
        end else begin
          assert (pad_aw.addr == aw_addr_q[0])
            else report_value("pad_aw.addr", pad_aw.addr, aw_addr_q[0]);
          assert (pad_aw.id == aw_id_q[0])
            else report_value("pad_aw.id", pad_aw.id, aw_id_q[0]);
          b_id_q.push_back(pad_aw.id);
          void'(aw_addr_q.pop_front());
          void'(aw_id_q.pop_front());
          aw_hs++;
        end
      end
      if (pad_wvalid && pad_wready) begin
        if (w_data_q.size() == 0) begin
          unexpected("W on the pad with no write accepted");
        end else begin
          assert (pad_w.data == w_data_q[0])
            else report_value("pad_w.data", pad_w.data, w_data_q[0]);
          assert (pad_w.strb == w_strb_q[0])
            else report_value("pad_w.strb", pad_w.strb, w_strb_q[0]);
          void'(w_data_q.pop_front());
          void'(w_strb_q.pop_front());
          w_hs++;
        end
      end
      if (ifu_rsp_valid) begin
        if (ifu_addr_q.size() == 0) begin
          unexpected("ifu response with no ifu read outstanding");
        end else begin
          assert (rd_rsp.data == rep(ifu_addr_q[0]))
            else report_value("rd_rsp.data", rd_rsp.data, rep(ifu_addr_q[0]));
          assert (rd_rsp.id == ifu_id_q[0])
            else report_value("rd_rsp.id", rd_rsp.id, ifu_id_q[0]);
          void'(ifu_addr_q.pop_front());
          void'(ifu_id_q.pop_front());
        end
      end
      if (lsu_rsp_valid) begin
        if (lsu_addr_q.size() == 0) begin
          unexpected("lsu response with no lsu read outstanding");
        end else begin
          assert (rd_rsp.data == rep(lsu_addr_q[0]))
            else report_value("rd_rsp.data", rd_rsp.data, rep(lsu_addr_q[0]));
          assert (rd_rsp.id == lsu_id_q[0])
            else report_value("rd_rsp.id", rd_rsp.id, lsu_id_q[0]);
          void'(lsu_addr_q.pop_front());
          void'(lsu_id_q.pop_front());
        end
      end
      if (pad_rvalid) begin
        void'(r_id_q.pop_front());
        void'(r_addr_q.pop_front());
        void'(r_due_q.pop_front());
      end
      if (pad_bvalid) begin
        void'(b_id_q.pop_front());
        b_cnt++;
      end
    end
  end

  // ============================================================
  // Drive core requests and slave responses after the edge
  // ============================================================
  always @(posedge forever_cpuclk) begin
    #1;
    if (!in_reset) begin
      rnd = next_bits(2);
      pad_arready = |rnd[1:0];
      rnd = next_bits(2);
      pad_awready = |rnd[1:0];
      rnd = next_bits(2);
      pad_wready = |rnd[1:0];
      pad_rvalid = (r_due_q.size() > 0) && (cycles >= r_due_q[0]);
      pad_r = '0;
      if (pad_rvalid) begin
        pad_r.data = rep(r_addr_q[0]);
        pad_r.id   = r_id_q[0];
        pad_r.last = 1'b1;
      end
      // B once both halves of a write were taken
      pad_bvalid = (b_cnt < aw_hs) && (b_cnt < w_hs) && (b_id_q.size() > 0);
      pad_b = '0;
      if (pad_bvalid)
        pad_b.id = b_id_q[0];
      ifu_rd_valid = ifu_idx < N_RD;
      ifu_rd_req   = make_rd(2'd0, ifu_idx);
      lsu_rd_valid = lsu_idx < N_RD;
      lsu_rd_req   = make_rd(2'd1, lsu_idx);
      stb_wr_valid = stb_idx < N_WR;
      stb_wr_req   = make_wr(2'd2, stb_idx);
      vb_wr_valid  = vb_idx < N_WR;
      vb_wr_req    = make_wr(2'd3, vb_idx);
    end
  end

  function automatic logic all_done();
    all_done = ifu_idx == N_RD && lsu_idx == N_RD && stb_idx == N_WR && vb_idx == N_WR
            && ifu_addr_q.size() == 0 && lsu_addr_q.size() == 0
            && r_due_q.size() == 0 && b_cnt == wr_acc && lsu_no_op;
  endfunction

  initial begin
    lfsr = 16'd16;
    reset = 1'b1;
    in_reset = 1'b1;
    rd_seen = 1'b0;
    rd_last_lsu = 1'b0;
    {ifu_rd_valid, lsu_rd_valid, stb_wr_valid, vb_wr_valid} = '0;
    ifu_rd_req = '0;
    lsu_rd_req = '0;
    stb_wr_req = '0;
    vb_wr_req = '0;
    {pad_arready, pad_awready, pad_wready, pad_rvalid, pad_bvalid} = '0;
    pad_r = '0;
    pad_b = '0;
    repeat (10) @(posedge forever_cpuclk);
    #1 reset = 1'b0;
    do @(posedge forever_cpuclk); while (!all_done() && cycles < CYCLE_LIMIT);
    if (!all_done()) begin
      $display("Timeout after %0d cycles with traffic still pending", cycles);
    end
    $display("errors: scoreboard %0d, assertions %0d", data_errors, assert_errors);
    if (all_done() && data_errors == 0 && assert_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/biu_top.sv ====
// ============================================================
// Bus interface unit top, arbiter plus read and write channels
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module biu_top (
  input  wire                        forever_cpuclk,
  input  wire                        reset,
  input  wire                        ifu_rd_valid,
  input  biu_req_pkg::core_rd_req_t  ifu_rd_req,
  output logic                       ifu_rd_ready,
  input  wire                        lsu_rd_valid,
  input  biu_req_pkg::core_rd_req_t  lsu_rd_req,
  output logic                       lsu_rd_ready,
  input  wire                        stb_wr_valid,
  input  biu_req_pkg::core_wr_req_t  stb_wr_req,
  output logic                       stb_wr_ready,
  input  wire                        vb_wr_valid,
  input  biu_req_pkg::core_wr_req_t  vb_wr_req,
  output logic                       vb_wr_ready,
  output logic                       ifu_rsp_valid,
  output logic                       lsu_rsp_valid,
  output biu_req_pkg::core_rd_rsp_t  rd_rsp,
  output logic                       lsu_no_op,
  output logic                       pad_arvalid,
  output biu_axi_pkg::axi_ar_t       pad_ar,
  input  wire                        pad_arready,
  output logic                       pad_awvalid,
  output biu_axi_pkg::axi_aw_t       pad_aw,
  input  wire                        pad_awready,
  output logic                       pad_wvalid,
  output biu_axi_pkg::axi_w_t        pad_w,
  input  wire                        pad_wready,
  input  wire                        pad_rvalid,
  input  biu_axi_pkg::axi_r_t        pad_r,
  input  wire                        pad_bvalid,
  input  biu_axi_pkg::axi_b_t        pad_b
);

  // Arbiter to channels
  logic                  ar_valid;
  biu_axi_pkg::axi_ar_t  ar_req;
  logic                  ar_ready;
  logic                  wr_valid;
  biu_axi_pkg::axi_aw_t  aw_req;
  biu_axi_pkg::axi_w_t   w_req;
  logic                  wr_ready;

  biu_req_arbiter u_arbiter (.*);

  biu_read_channel u_read_channel (.*);

  biu_write_channel u_write_channel (.*);

endmodule

`default_nettype wire

// ==== source/biu_write_channel.sv ====
// ============================================================
// AW and W register slices, outstanding write counter
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module biu_write_channel (
  input  wire                   forever_cpuclk,
  input  wire                   reset,
  input  wire                   wr_valid,
  input  biu_axi_pkg::axi_aw_t  aw_req,
  input  biu_axi_pkg::axi_w_t   w_req,
  output logic                  wr_ready,
  output logic                  pad_awvalid,
  output biu_axi_pkg::axi_aw_t  pad_aw,
  input  wire                   pad_awready,
  output logic                  pad_wvalid,
  output biu_axi_pkg::axi_w_t   pad_w,
  input  wire                   pad_wready,
  input  wire                   pad_bvalid,
  input  biu_axi_pkg::axi_b_t   pad_b,
  output logic                  lsu_no_op
);

  logic                              aw_full;
  logic                              w_full;
  biu_axi_pkg::axi_aw_t              aw_q;
  biu_axi_pkg::axi_w_t               w_q;
  logic [biu_req_pkg::WR_CNT_W-1:0]  wr_cnt;
  logic [biu_req_pkg::WR_CNT_W:0]    wr_pend;
  logic                              wr_fire;
  logic                              aw_fire;
  biu_req_pkg::biu_src_e             b_src;

  // ============================================================
  // Accept and slices
  // ============================================================
  // A write still in the AW slice already holds a counter slot
  assign wr_pend  = wr_cnt + aw_full;
  assign wr_ready = (~aw_full | pad_awready) & (~w_full | pad_wready)
                  & (wr_pend < biu_req_pkg::MAX_WR_OUTSTANDING);
  assign wr_fire  = wr_valid & wr_ready;
  assign aw_fire  = pad_awvalid & pad_awready;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      aw_full <= wr_fire | (aw_full & ~pad_awready);
      w_full  <= wr_fire | (w_full & ~pad_wready);
    end
  end

  // AW and W load together, drain apart
  always_ff @(posedge forever_cpuclk) begin
    if (wr_fire) begin
      aw_q <= aw_req;
      w_q  <= w_req;
    end
  end

  assign pad_awvalid = aw_full;
  assign pad_aw      = aw_q;
  assign pad_wvalid  = w_full;
  assign pad_w       = w_q;

  // ============================================================
  // Outstanding counter
  // ============================================================
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      wr_cnt <= '0;
    end else begin
      case ({aw_fire, pad_bvalid})
        2'b10:   wr_cnt <= wr_cnt + 1'b1;
        2'b01:   wr_cnt <= wr_cnt - 1'b1;
        default: wr_cnt <= wr_cnt;
      endcase
    end
  end

  assign lsu_no_op = (wr_cnt == '0) & ~aw_full & ~w_full;

  assign b_src = biu_req_pkg::biu_src_e'(pad_b.id[biu_axi_pkg::AXI_ID_W-1 -: 2]);

  // From zero the count can only hold or step up; a wrap lands on all ones
  a_no_underflow: assert property (@(posedge forever_cpuclk) disable iff (reset)
    wr_cnt == '0 |=> wr_cnt <= 1);

  // B only for an AW that went out, tagged by a write source
  a_b_expected: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_bvalid |-> (wr_cnt != '0)
      && ((b_src == biu_req_pkg::src_stb) || (b_src == biu_req_pkg::src_vb)));

endmodule

`default_nettype wire

// ==== source/biu_read_channel.sv ====
// ============================================================
// AR register slice and read response routing
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module biu_read_channel (
  input  wire                        forever_cpuclk,
  input  wire                        reset,
  input  wire                        ar_valid,
  input  biu_axi_pkg::axi_ar_t       ar_req,
  output logic                       ar_ready,
  output logic                       pad_arvalid,
  output biu_axi_pkg::axi_ar_t       pad_ar,
  input  wire                        pad_arready,
  input  wire                        pad_rvalid,
  input  biu_axi_pkg::axi_r_t        pad_r,
  output logic                       ifu_rsp_valid,
  output logic                       lsu_rsp_valid,
  output biu_req_pkg::core_rd_rsp_t  rd_rsp
);

  logic                  ar_full;
  biu_axi_pkg::axi_ar_t  ar_q;
  biu_req_pkg::biu_src_e r_src;

  // ============================================================
  // AR slice
  // ============================================================
  // Room when empty or draining this cycle
  assign ar_ready = ~ar_full | pad_arready;

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ar_full <= 1'b0;
    end else if (ar_ready) begin
      ar_full <= ar_valid;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (ar_valid && ar_ready) begin
      ar_q <= ar_req;
    end
  end

  assign pad_arvalid = ar_full;
  assign pad_ar      = ar_q;

  // ============================================================
  // Response routing
  // ============================================================
  assign r_src = biu_req_pkg::biu_src_e'(pad_r.id[biu_axi_pkg::AXI_ID_W-1 -: 2]);

  assign ifu_rsp_valid = pad_rvalid & (r_src == biu_req_pkg::src_ifu);
  assign lsu_rsp_valid = pad_rvalid & (r_src == biu_req_pkg::src_lsu);

  // Shared by both destinations with the local id only
  assign rd_rsp.data = pad_r.data;
  assign rd_rsp.id   = pad_r.id[biu_req_pkg::LOCAL_ID_W-1:0];
  assign rd_rsp.resp = pad_r.resp;
  assign rd_rsp.last = pad_r.last;

  // Only the arbiter's read tags can come back on R
  a_r_tag: assert property (@(posedge forever_cpuclk) disable iff (reset)
    pad_rvalid |-> (r_src == biu_req_pkg::src_ifu) || (r_src == biu_req_pkg::src_lsu));

endmodule

`default_nettype wire

// ==== source/biu_req_arbiter.sv ====
// ============================================================
// Read and write request arbiter with AXI id tagging
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module biu_req_arbiter (
  input  wire                        forever_cpuclk,
  input  wire                        reset,
  input  wire                        ifu_rd_valid,
  input  biu_req_pkg::core_rd_req_t  ifu_rd_req,
  output logic                       ifu_rd_ready,
  input  wire                        lsu_rd_valid,
  input  biu_req_pkg::core_rd_req_t  lsu_rd_req,
  output logic                       lsu_rd_ready,
  input  wire                        stb_wr_valid,
  input  biu_req_pkg::core_wr_req_t  stb_wr_req,
  output logic                       stb_wr_ready,
  input  wire                        vb_wr_valid,
  input  biu_req_pkg::core_wr_req_t  vb_wr_req,
  output logic                       vb_wr_ready,
  output logic                       ar_valid,
  output biu_axi_pkg::axi_ar_t       ar_req,
  input  wire                        ar_ready,
  output logic                       wr_valid,
  output biu_axi_pkg::axi_aw_t       aw_req,
  output biu_axi_pkg::axi_w_t        w_req,
  input  wire                        wr_ready
);

  biu_req_pkg::rd_grant_e    rd_last;
  logic                      ifu_win;
  biu_req_pkg::core_rd_req_t rd_sel;
  biu_req_pkg::biu_src_e     rd_src;
  biu_req_pkg::core_wr_req_t wr_sel;
  biu_req_pkg::biu_src_e     wr_src;

  // Tag in the top bits, local id in the bottom, zeros between
  function automatic logic [biu_axi_pkg::AXI_ID_W-1:0] make_id(
    input biu_req_pkg::biu_src_e              src,
    input logic [biu_req_pkg::LOCAL_ID_W-1:0] lid
  );
    make_id = {src, {(biu_axi_pkg::AXI_ID_W - 2 - biu_req_pkg::LOCAL_ID_W){1'b0}}, lid};
  endfunction

  // ============================================================
  // Round-robin read side
  // ============================================================
  assign ifu_win  = ifu_rd_valid & (~lsu_rd_valid | (rd_last == biu_req_pkg::last_lsu));
  assign ar_valid = ifu_rd_valid | lsu_rd_valid;
  assign rd_sel   = ifu_win ? ifu_rd_req : lsu_rd_req;
  assign rd_src   = ifu_win ? biu_req_pkg::src_ifu : biu_req_pkg::src_lsu;

  assign ifu_rd_ready = ifu_win & ar_ready;
  assign lsu_rd_ready = lsu_rd_valid & ~ifu_win & ar_ready;

  // Reset to lsu so ifu gets the first turn
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      rd_last <= biu_req_pkg::last_lsu;
    end else if (ifu_rd_ready) begin
      rd_last <= biu_req_pkg::last_ifu;
    end else if (lsu_rd_ready) begin
      rd_last <= biu_req_pkg::last_lsu;
    end
  end

  always_comb begin
    ar_req       = '0;
    ar_req.addr  = rd_sel.addr;
    ar_req.id    = make_id(rd_src, rd_sel.id);
    ar_req.size  = rd_sel.size;
    ar_req.burst = rd_sel.burst;
    ar_req.cache = rd_sel.cache;
    ar_req.prot  = rd_sel.prot;
  end

  // ============================================================
  // Write side with victim buffer priority
  // ============================================================
  assign wr_valid = vb_wr_valid | stb_wr_valid;
  assign wr_sel   = vb_wr_valid ? vb_wr_req : stb_wr_req;
  assign wr_src   = vb_wr_valid ? biu_req_pkg::src_vb : biu_req_pkg::src_stb;

  assign vb_wr_ready  = vb_wr_valid & wr_ready;
  assign stb_wr_ready = stb_wr_valid & ~vb_wr_valid & wr_ready;

  always_comb begin
    aw_req       = '0;
    aw_req.addr  = wr_sel.addr;
    aw_req.id    = make_id(wr_src, wr_sel.id);
    aw_req.size  = wr_sel.size;
    aw_req.burst = wr_sel.burst;
    aw_req.cache = wr_sel.cache;
    aw_req.prot  = wr_sel.prot;
    w_req.data   = wr_sel.data;
    w_req.strb   = wr_sel.strb;
    w_req.last   = wr_sel.last;
  end

  a_one_ready: assert property (@(posedge forever_cpuclk) disable iff (reset)
    $onehot0({ifu_rd_ready, lsu_rd_ready}) && $onehot0({stb_wr_ready, vb_wr_ready}));

endmodule

`default_nettype wire

// ==== source/biu_req_pkg.sv ====
// ============================================================
// Core-side request and response structs, source tags
// ============================================================
`default_nettype none

package biu_req_pkg;

  localparam int LOCAL_ID_W         = 4;
  localparam int MAX_WR_OUTSTANDING = 7;
  localparam int WR_CNT_W           = $clog2(MAX_WR_OUTSTANDING + 1);

  // Upper two bits of the AXI id
  typedef enum logic [1:0] {
    src_ifu = 2'd0,
    src_lsu = 2'd1,
    src_stb = 2'd2,
    src_vb  = 2'd3
  } biu_src_e;

  // Last read winner for round-robin
  typedef enum logic {
    last_ifu = 1'b0,
    last_lsu = 1'b1
  } rd_grant_e;

  typedef struct packed {
    logic [biu_axi_pkg::ADDR_W-1:0] addr;
    logic [LOCAL_ID_W-1:0]          id;
    logic [2:0]                     size;
    logic [1:0]                     burst;
    logic [3:0]                     cache;
    logic [2:0]                     prot;
  } core_rd_req_t;

  typedef struct packed {
    logic [biu_axi_pkg::ADDR_W-1:0] addr;
    logic [LOCAL_ID_W-1:0]          id;
    logic [2:0]                     size;
    logic [1:0]                     burst;
    logic [3:0]                     cache;
    logic [2:0]                     prot;
    logic [biu_axi_pkg::DATA_W-1:0] data;
    logic [biu_axi_pkg::STRB_W-1:0] strb;
    logic                           last;
  } core_wr_req_t;

  typedef struct packed {
    logic [biu_axi_pkg::DATA_W-1:0] data;
    logic [LOCAL_ID_W-1:0]          id;
    logic [1:0]                     resp;
    logic                           last;
  } core_rd_rsp_t;

endpackage

`default_nettype wire

// ==== source/biu_axi_pkg.sv ====
// ============================================================
// AXI bus widths and channel payload structs
// ============================================================
`default_nettype none

package biu_axi_pkg;

  // ============================================================
  // Bus widths
  // ============================================================
  localparam int ADDR_W   = 40;
  localparam int DATA_W   = 128;
  localparam int STRB_W   = 16;
  localparam int AXI_ID_W = 8;

  // ============================================================
  // Channel payloads
  // ============================================================
  // Read address
  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic [AXI_ID_W-1:0] id;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
    logic [3:0]          cache;
    logic [2:0]          prot;
  } axi_ar_t;

  // Write address has the same field layout
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
    logic                last;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

endpackage

`default_nettype wire
